//--- Bender.yml
package:
  name: xvid

export_include_dirs:
  - .

sources:
  - xvid_pkg.sv
  - bus_sync.sv
  - xvid_regs.sv
  - vram_init.sv
  - mem_port.sv
  - xvid_top.sv
  - target: simulation
    files:
      - xvid_properties.sv
      - tb_xvid.sv

//--- bus_sync.sv
/*
 * brings the slow asynchronous host bus into the clock domain
 * one strobe per falling edge of the select, with the byte access captured
 */
`include "xvid_macros.svh"

module bus_sync (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bus_cs_n_i,
    input  logic                bus_rd_nwr_i,       // 0 write, 1 read
    input  logic                bus_bytesel_i,      // 0 even, 1 odd
    input  xvid_pkg::reg_num_t  bus_reg_num_i,
    input  xvid_pkg::byte_t     bus_data_i,
    output xvid_pkg::bus_acc_t  acc_o
);

    localparam int STAGES = `XV_SYNC_STAGES;

    logic [STAGES:0] cs_n_sync;             // top bit is the previous synced value
    logic            cs_fall;

    assign cs_fall = cs_n_sync[STAGES] & ~cs_n_sync[STAGES-1];

    always_ff @(posedge clk) begin
        // other bus pins are stable while select is low
        if (cs_fall) begin
            acc_o.reg_num <= bus_reg_num_i;
            acc_o.bytesel <= bus_bytesel_i;
            acc_o.data    <= bus_data_i;
        end

        if (reset_i) begin
            cs_n_sync   <= '1;              // deselected
            acc_o.write <= 1'b0;
            acc_o.read  <= 1'b0;
        end
        else begin
            cs_n_sync   <= {cs_n_sync[STAGES-1:0], bus_cs_n_i};
            acc_o.write <= cs_fall & ~bus_rd_nwr_i;
            acc_o.read  <= cs_fall & bus_rd_nwr_i;
        end
    end

endmodule

//--- files.f
+incdir+.
xvid_pkg.sv
bus_sync.sv
xvid_regs.sv
vram_init.sv
mem_port.sv
xvid_top.sv
xvid_properties.sv
tb_xvid.sv

//--- mem_port.sv
/*
 * shared VRAM/AUX port, clear requests win while the clear runs
 * pins hold while the video generator has the memory
 */
module mem_port (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                vgen_sel_i,
    input  logic                clear_busy_i,
    input  xvid_pkg::mem_req_t  init_req_i,
    input  xvid_pkg::mem_req_t  regs_req_i,
    input  xvid_pkg::word_t     blit_data_i,    // VRAM read data
    input  xvid_pkg::word_t     aux_data_i,     // AUX read data
    output logic                blit_vram_sel_o,
    output logic                blit_aux_sel_o,
    output logic                blit_wr_o,
    output xvid_pkg::word_t     blit_addr_o,
    output xvid_pkg::word_t     blit_data_o,
    output xvid_pkg::mem_rsp_t  rsp_o
);

    xvid_pkg::mem_req_t req;
    logic               req_new;
    logic               free;
    logic               vram_rd_ack;
    logic               aux_rd_ack;

    assign req     = clear_busy_i ? init_req_i : regs_req_i;
    assign req_new = req.vram | req.aux;
    assign free    = ~vgen_sel_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            blit_vram_sel_o <= 1'b0;
            blit_aux_sel_o  <= 1'b0;
            blit_wr_o       <= 1'b0;
            vram_rd_ack     <= 1'b0;
            aux_rd_ack      <= 1'b0;
        end
        else begin
            // read completes in a free cycle, data comes back next cycle
            vram_rd_ack <= blit_vram_sel_o & ~blit_wr_o & free;
            aux_rd_ack  <= blit_aux_sel_o & ~blit_wr_o & free;

            if (req_new) begin
                blit_vram_sel_o <= req.vram;    // replaces any held access
                blit_aux_sel_o  <= req.aux;
                blit_wr_o       <= req.wr;
            end
            else if (free) begin
                blit_vram_sel_o <= 1'b0;
                blit_aux_sel_o  <= 1'b0;
                blit_wr_o       <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_new) begin
            blit_addr_o <= req.addr;
            blit_data_o <= req.data;
        end
    end

    assign rsp_o.vram_valid = vram_rd_ack;
    assign rsp_o.aux_valid  = aux_rd_ack;
    assign rsp_o.data       = aux_rd_ack ? aux_data_i : blit_data_i;

endmodule

//--- tb_xvid.sv
/*
 * testbench for the video register block, drives the host bus and models VRAM/AUX
 * the bound property module does the checking
 */
module tb_xvid;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLEAR_WORDS = 64;
    localparam int unsigned NUM_ACC     = 66;   // host byte accesses in the stimulus
    localparam int unsigned SEED        = 32'h3911_ce0a;

    logic               clk;
    logic               reset_i;
    logic               cs_n;
    logic               rd_nwr;
    logic               bytesel;
    xvid_pkg::reg_num_t reg_num;
    xvid_pkg::byte_t    wdata;
    xvid_pkg::byte_t    rdata;
    logic               vgen_sel;
    logic               vgen_ena;
    logic               vram_sel;
    logic               aux_sel;
    logic               wr;
    xvid_pkg::word_t    addr;
    xvid_pkg::word_t    blit_rdata;
    xvid_pkg::word_t    blit_wdata;
    xvid_pkg::word_t    aux_rdata;

    xvid_pkg::word_t    vram [65536];
    xvid_pkg::word_t    aux_mem [256];

    xvid_top #(
        .CLEAR_WORDS     (CLEAR_WORDS)
    ) dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .bus_cs_n_i      (cs_n),
        .bus_rd_nwr_i    (rd_nwr),
        .bus_bytesel_i   (bytesel),
        .bus_reg_num_i   (reg_num),
        .bus_data_i      (wdata),
        .bus_data_o      (rdata),
        .vgen_sel_i      (vgen_sel),
        .vgen_ena_o      (vgen_ena),
        .blit_vram_sel_o (vram_sel),
        .blit_aux_sel_o  (aux_sel),
        .blit_wr_o       (wr),
        .blit_addr_o     (addr),
        .blit_data_i     (blit_rdata),
        .blit_data_o     (blit_wdata),
        .aux_data_i      (aux_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory models, read combinationally, written in a free cycle
    assign blit_rdata = vram[addr];
    assign aux_rdata  = aux_mem[addr[7:0]];

    always @(posedge clk) begin
        if (wr && !vgen_sel) begin
            if (vram_sel) vram[addr] <= blit_wdata;
            if (aux_sel) aux_mem[addr[7:0]] <= blit_wdata;
        end
    end

    task automatic drive_vgen();
        forever begin
            @(posedge clk);
            #1 vgen_sel = ($urandom % 100) < 30;    // video owns memory ~30 %
        end
    endtask

    // one byte access, select low 6 cycles and high 4
    task automatic bus_access(input logic rd, input xvid_pkg::reg_num_t r,
                              input logic sel, input xvid_pkg::byte_t d);
        @(posedge clk);
        #1;
        rd_nwr  = rd;
        reg_num = r;
        bytesel = sel;
        wdata   = d;
        cs_n    = 1'b0;
        repeat (6) @(posedge clk);
        #1 cs_n = 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic write_word(input xvid_pkg::reg_num_t r, input xvid_pkg::word_t v);
        bus_access(1'b0, r, 1'b0, v[15:8]);
        bus_access(1'b0, r, 1'b1, v[7:0]);
    endtask

    task automatic read_word(input xvid_pkg::reg_num_t r);
        bus_access(1'b1, r, 1'b0, 8'h00);
        bus_access(1'b1, r, 1'b1, 8'h00);
    endtask

    initial begin
        wait (dut.u_props.fail_count != 0);
        $display("STATUS: FAIL");
        $fatal(1, "assertion failed in the bound checker");
    end

    initial begin
        repeat (16 + CLEAR_WORDS * 4 + 400 * NUM_ACC) @(posedge clk);
        $display("STATUS: FAIL");
        $fatal(1, "timeout, stimulus did not complete");
    end

    initial begin
        xvid_pkg::reg_num_t rw_regs [4];
        rw_regs = '{xvid_pkg::AUX_ADDR, xvid_pkg::CONST, xvid_pkg::RD_ADDR, xvid_pkg::WR_ADDR};
        void'($urandom(SEED));
        for (int i = 0; i < 65536; i++) begin
            vram[i] = {i[7:0], i[15:8]} ^ 16'h1d2e;
        end
        for (int i = 0; i < 256; i++) begin
            aux_mem[i] = {i[7:0] ^ 8'ha5, i[7:0]};
        end
        cs_n     = 1'b1;
        rd_nwr   = 1'b0;
        bytesel  = 1'b0;
        reg_num  = xvid_pkg::AUX_ADDR;
        wdata    = 8'h00;
        vgen_sel = 1'b0;
        reset_i  = 1'b1;
        fork
            drive_vgen();
        join_none
        repeat (16) @(posedge clk);
        #1 reset_i = 1'b0;

        read_word(xvid_pkg::STATUS);                // clear still running
        wait (vgen_ena === 1'b1);
        read_word(xvid_pkg::STATUS);

        foreach (rw_regs[i]) begin
            write_word(rw_regs[i], 16'($urandom));
            read_word(rw_regs[i]);
        end

        write_word(xvid_pkg::WR_INC, 16'd3);
        write_word(xvid_pkg::WR_ADDR, 16'h0100);
        repeat (4) write_word(xvid_pkg::DATA, 16'($urandom));
        write_word(xvid_pkg::RD_INC, 16'd3);
        write_word(xvid_pkg::RD_ADDR, 16'h0100);
        repeat (4) read_word(xvid_pkg::DATA);
        write_word(xvid_pkg::RD_ADDR, 16'h0020);    // inside the cleared area
        read_word(xvid_pkg::DATA_2);

        write_word(xvid_pkg::AUX_ADDR, 16'h0010);
        repeat (3) write_word(xvid_pkg::AUX_DATA, 16'($urandom));
        write_word(xvid_pkg::AUX_ADDR, 16'h0010);
        read_word(xvid_pkg::AUX_DATA);
        write_word(xvid_pkg::AUX_ADDR, 16'h0011);
        read_word(xvid_pkg::AUX_DATA);
        read_word(xvid_pkg::AUX_ADDR);

        repeat (4) @(posedge clk);
        if (dut.u_props.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end
        else begin
            $display("STATUS: FAIL");
            $fatal(1, "assertion failed in the bound checker");
        end
    end

endmodule

//--- vram_init.sv
/*
 * power-on VRAM clear, one word per free memory cycle
 * video output is enabled once the last word is written
 */
`include "xvid_macros.svh"

module vram_init #(
    parameter int unsigned CLEAR_WORDS = `XV_CLEAR_WORDS
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                vgen_sel_i,     // video generator owns memory
    output logic                clear_busy_o,
    output xvid_pkg::mem_req_t  req_o,
    output logic                vgen_ena_o
);

    xvid_pkg::init_state_t state;
    logic [16:0]           clear_cnt;           // words issued so far
    logic                  all_issued;
    logic                  issue;

    assign all_issued = (clear_cnt == 17'(CLEAR_WORDS));
    assign issue      = (state == xvid_pkg::CLEAR) & ~all_issued & ~vgen_sel_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= xvid_pkg::INIT;
            clear_cnt <= '0;
        end
        else begin
            case (state)
                xvid_pkg::INIT: state <= xvid_pkg::CLEAR;
                xvid_pkg::CLEAR: begin
                    if (issue) begin
                        clear_cnt <= clear_cnt + 17'd1;
                    end
                    // free cycle here completes the last write on the pins
                    if (all_issued && !vgen_sel_i) begin
                        state <= xvid_pkg::DONE;
                    end
                end
                default: ;
            endcase
        end
    end

    assign req_o.vram = issue;
    assign req_o.aux  = 1'b0;
    assign req_o.wr   = 1'b1;
    assign req_o.addr = clear_cnt[15:0];
    assign req_o.data = `XV_CLEAR_DATA;

    assign clear_busy_o = (state != xvid_pkg::DONE);
    assign vgen_ena_o   = (state == xvid_pkg::DONE);

endmodule

//--- xvid_macros.svh
/*
 * build-time constants for the video register block
 * include wherever a module needs the clear or synchronizer settings
 */
`ifndef XVID_MACROS_SVH
`define XVID_MACROS_SVH

// number of VRAM words written by the power-on clear
// default for a full tile map, xvid_top takes a smaller CLEAR_WORDS for simulation
`define XV_CLEAR_WORDS 4096

// value written to every cleared word (blue background, white space tile)
`define XV_CLEAR_DATA 16'h0220

// flip-flops on the bus select before edge detection
`define XV_SYNC_STAGES 2

`endif

//--- xvid_pkg.sv
/*
 * shared types of the video register block
 * register map, word types, memory request and response bundles
 */
package xvid_pkg;

    typedef logic [15:0] word_t;            // VRAM/AUX data or address
    typedef logic [7:0]  byte_t;            // host bus byte

    // host visible register numbers, 10 to 15 unused
    typedef enum logic [3:0] {
        AUX_ADDR = 4'h0,
        CONST    = 4'h1,
        RD_ADDR  = 4'h2,
        WR_ADDR  = 4'h3,
        DATA     = 4'h4,
        DATA_2   = 4'h5,
        AUX_DATA = 4'h6,
        STATUS   = 4'h7,
        RD_INC   = 4'h8,
        WR_INC   = 4'h9
    } reg_num_t;

    // one completed host byte access
    typedef struct packed {
        logic     write;                    // single cycle strobe
        logic     read;                     // single cycle strobe
        reg_num_t reg_num;
        logic     bytesel;                  // 0 even, 1 odd
        byte_t    data;
    } bus_acc_t;

    // one memory access request, present while vram or aux is high
    typedef struct packed {
        logic  vram;
        logic  aux;
        logic  wr;
        word_t addr;
        word_t data;
    } mem_req_t;

    // read data returned to the register file
    typedef struct packed {
        logic  vram_valid;                  // one cycle pulse
        logic  aux_valid;                   // one cycle pulse
        word_t data;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        INIT,
        CLEAR,
        DONE
    } init_state_t;

endpackage

//--- xvid_properties.sv
/*
 * bound checker for the video register block
 * shadow registers follow the host strobes, assertions compare the port behavior
 */
`include "xvid_macros.svh"

module xvid_properties #(
    parameter int unsigned CLEAR_WORDS = `XV_CLEAR_WORDS
) (
    input logic                clk,
    input logic                reset_i,
    input xvid_pkg::bus_acc_t  acc_i,           // synchronized host strobe
    input xvid_pkg::byte_t     bus_data_o,
    input logic                vgen_sel_i,
    input logic                vgen_ena_o,
    input logic                blit_vram_sel_o,
    input logic                blit_aux_sel_o,
    input logic                blit_wr_o,
    input xvid_pkg::word_t     blit_addr_o,
    input xvid_pkg::word_t     blit_data_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned        fail_count = 0;     // watched by the testbench
    int unsigned        clear_cnt;          // clear writes seen so far

    xvid_pkg::word_t    sh_aux_addr;
    xvid_pkg::word_t    sh_const;
    xvid_pkg::word_t    sh_rd_addr;
    xvid_pkg::word_t    sh_wr_addr;
    xvid_pkg::word_t    sh_rd_inc;
    xvid_pkg::word_t    sh_wr_inc;
    xvid_pkg::word_t    sh_vram_rd;
    xvid_pkg::word_t    sh_aux_rd;
    xvid_pkg::byte_t    sh_data_even;
    xvid_pkg::byte_t    sh_other_even;
    xvid_pkg::reg_num_t sh_other_reg;
    xvid_pkg::word_t    sh_vram [65536];
    xvid_pkg::word_t    sh_aux [256];

    xvid_pkg::mem_req_t exp_req;            // request the strobe should produce
    xvid_pkg::mem_req_t pend;
    logic               pend_valid;
    xvid_pkg::word_t    exp_word;
    xvid_pkg::byte_t    exp_byte;
    xvid_pkg::byte_t    tagged_even;
    logic               clear_done;
    logic               clear_write;
    logic               wr_odd;
    logic               rd_data;
    logic               is_data;
    logic [34:0]        blit_pins;

    assign clear_done  = (clear_cnt == CLEAR_WORDS);
    assign clear_write = blit_vram_sel_o & blit_wr_o & ~vgen_sel_i & ~clear_done;
    assign is_data     = (acc_i.reg_num == xvid_pkg::DATA) || (acc_i.reg_num == xvid_pkg::DATA_2);
    assign wr_odd      = acc_i.write & acc_i.bytesel;
    assign rd_data     = acc_i.read & acc_i.bytesel & is_data;
    assign tagged_even = (sh_other_reg == acc_i.reg_num) ? sh_other_even : 8'h00;
    assign blit_pins   = {blit_vram_sel_o, blit_aux_sel_o, blit_wr_o, blit_addr_o, blit_data_o};

    always_comb begin
        exp_req = '0;
        if (wr_odd) begin
            case (acc_i.reg_num)
                xvid_pkg::AUX_ADDR: begin
                    exp_req.aux  = 1'b1;
                    exp_req.addr = {sh_aux_addr[15:8], acc_i.data};
                end
                xvid_pkg::RD_ADDR: begin
                    exp_req.vram = 1'b1;
                    exp_req.addr = {sh_rd_addr[15:8], acc_i.data};
                end
                xvid_pkg::DATA,
                xvid_pkg::DATA_2: begin
                    exp_req = '{vram: 1'b1, aux: 1'b0, wr: 1'b1, addr: sh_wr_addr,
                                data: {sh_data_even, acc_i.data}};
                end
                xvid_pkg::AUX_DATA: begin
                    exp_req = '{vram: 1'b0, aux: 1'b1, wr: 1'b1, addr: sh_aux_addr,
                                data: {tagged_even, acc_i.data}};
                end
                default: ;
            endcase
        end
        if (rd_data) begin
            exp_req.vram = 1'b1;
            exp_req.addr = sh_rd_addr;
        end
    end

    always_comb begin
        case (acc_i.reg_num)
            xvid_pkg::AUX_ADDR: exp_word = sh_aux_addr;
            xvid_pkg::CONST:    exp_word = sh_const;
            xvid_pkg::RD_ADDR:  exp_word = sh_rd_addr;
            xvid_pkg::WR_ADDR:  exp_word = sh_wr_addr;
            xvid_pkg::DATA,
            xvid_pkg::DATA_2:   exp_word = sh_vram_rd;
            xvid_pkg::AUX_DATA: exp_word = sh_aux_rd;
            xvid_pkg::STATUS:   exp_word = clear_done ? 16'h0000 : 16'h8080;
            default:            exp_word = 16'h0000;
        endcase
        exp_byte = acc_i.bytesel ? exp_word[7:0] : exp_word[15:8];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            clear_cnt     <= 0;
            pend_valid    <= 1'b0;
            sh_aux_addr   <= '0;
            sh_const      <= '0;
            sh_rd_addr    <= '0;
            sh_wr_addr    <= '0;
            sh_rd_inc     <= '0;
            sh_wr_inc     <= '0;
            sh_data_even  <= '0;
            sh_other_even <= '0;
            sh_other_reg  <= xvid_pkg::AUX_ADDR;
        end
        else begin
            if (clear_write) begin
                sh_vram[clear_cnt[15:0]] <= `XV_CLEAR_DATA;
                clear_cnt <= clear_cnt + 1;
            end
            pend       <= exp_req;
            pend_valid <= (exp_req.vram | exp_req.aux) & clear_done;

            if (acc_i.write && !acc_i.bytesel) begin
                case (acc_i.reg_num)
                    xvid_pkg::AUX_ADDR: sh_aux_addr[15:8] <= acc_i.data;
                    xvid_pkg::RD_ADDR:  sh_rd_addr[15:8]  <= acc_i.data;
                    xvid_pkg::WR_ADDR:  sh_wr_addr[15:8]  <= acc_i.data;
                    xvid_pkg::DATA,
                    xvid_pkg::DATA_2:   sh_data_even      <= acc_i.data;
                    default: begin
                        sh_other_even <= acc_i.data;
                        sh_other_reg  <= acc_i.reg_num;
                    end
                endcase
            end

            if (wr_odd) begin
                case (acc_i.reg_num)
                    xvid_pkg::AUX_ADDR: sh_aux_addr[7:0] <= acc_i.data;
                    xvid_pkg::CONST:    sh_const         <= {tagged_even, acc_i.data};
                    xvid_pkg::RD_ADDR:  sh_rd_addr[7:0]  <= acc_i.data;
                    xvid_pkg::WR_ADDR:  sh_wr_addr[7:0]  <= acc_i.data;
                    xvid_pkg::DATA,
                    xvid_pkg::DATA_2: begin
                        sh_vram[sh_wr_addr] <= exp_req.data;
                        sh_wr_addr          <= sh_wr_addr + sh_wr_inc;
                    end
                    xvid_pkg::AUX_DATA: begin
                        sh_aux[sh_aux_addr[7:0]] <= exp_req.data;
                        sh_aux_addr              <= sh_aux_addr + 16'd1;
                    end
                    xvid_pkg::RD_INC:   sh_rd_inc <= {tagged_even, acc_i.data};
                    xvid_pkg::WR_INC:   sh_wr_inc <= {tagged_even, acc_i.data};
                    default: ;
                endcase
            end

            // fetched word as the model holds it now
            if (exp_req.vram && !exp_req.wr) begin
                sh_vram_rd <= sh_vram[exp_req.addr];
            end
            if (exp_req.aux && !exp_req.wr) begin
                sh_aux_rd <= sh_aux[exp_req.addr[7:0]];
            end
            if (rd_data) begin
                sh_rd_addr <= sh_rd_addr + sh_rd_inc;
            end
        end
    end

    a_clear_addr: assert property (@(posedge clk) disable iff (reset_i)
        clear_write |-> blit_addr_o == clear_cnt[15:0])
    else begin
        $error("MISMATCH blit_addr_o exp %h got %h", $sampled(clear_cnt[15:0]),
               $sampled(blit_addr_o));
        fail_count++;
    end

    a_clear_data: assert property (@(posedge clk) disable iff (reset_i)
        clear_write |-> blit_data_o == `XV_CLEAR_DATA)
    else begin
        $error("MISMATCH blit_data_o exp %h got %h", `XV_CLEAR_DATA, $sampled(blit_data_o));
        fail_count++;
    end

    a_ena_early: assert property (@(posedge clk) disable iff (reset_i)
        vgen_ena_o |-> clear_done)
    else begin
        $error("video output enabled before the clear wrote every word");
        fail_count++;
    end

    a_ena_rise: assert property (@(posedge clk) disable iff (reset_i)
        $rose(vgen_ena_o) |-> $past(clear_write))
    else begin
        $error("video output enable did not follow the last clear write");
        fail_count++;
    end

    a_req_sel: assert property (@(posedge clk) disable iff (reset_i)
        pend_valid |->
            {blit_vram_sel_o, blit_aux_sel_o, blit_wr_o} == {pend.vram, pend.aux, pend.wr})
    else begin
        $error("MISMATCH blit vram/aux/wr exp %h got %h",
               $sampled({pend.vram, pend.aux, pend.wr}),
               $sampled({blit_vram_sel_o, blit_aux_sel_o, blit_wr_o}));
        fail_count++;
    end

    a_req_addr: assert property (@(posedge clk) disable iff (reset_i)
        pend_valid |-> blit_addr_o == pend.addr)
    else begin
        $error("MISMATCH blit_addr_o exp %h got %h", $sampled(pend.addr), $sampled(blit_addr_o));
        fail_count++;
    end

    a_req_data: assert property (@(posedge clk) disable iff (reset_i)
        pend_valid && pend.wr |-> blit_data_o == pend.data)
    else begin
        $error("MISMATCH blit_data_o exp %h got %h", $sampled(pend.data), $sampled(blit_data_o));
        fail_count++;
    end

    a_readback: assert property (@(posedge clk) disable iff (reset_i)
        acc_i.read |-> bus_data_o == exp_byte)
    else begin
        $error("MISMATCH bus_data_o exp %h got %h", $sampled(exp_byte), $sampled(bus_data_o));
        fail_count++;
    end

    // pins frozen while the video generator owns memory and nothing new arrives
    a_hold: assert property (@(posedge clk) disable iff (reset_i)
        vgen_sel_i && !(exp_req.vram || exp_req.aux) |=> blit_pins === $past(blit_pins))
    else begin
        $error("MISMATCH blit pins exp %h got %h", $past(blit_pins), $sampled(blit_pins));
        fail_count++;
    end

endmodule

bind xvid_top xvid_properties #(
    .CLEAR_WORDS     (CLEAR_WORDS)
) u_props (
    .clk             (clk),
    .reset_i         (reset_i),
    .acc_i           (acc),
    .bus_data_o      (bus_data_o),
    .vgen_sel_i      (vgen_sel_i),
    .vgen_ena_o      (vgen_ena_o),
    .blit_vram_sel_o (blit_vram_sel_o),
    .blit_aux_sel_o  (blit_aux_sel_o),
    .blit_wr_o       (blit_wr_o),
    .blit_addr_o     (blit_addr_o),
    .blit_data_o     (blit_data_o)
);

//--- xvid_regs.sv
/*
 * host register file, assembles 16-bit values from byte writes
 * and turns data register accesses into VRAM or AUX requests
 */
module xvid_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  xvid_pkg::bus_acc_t  acc_i,
    input  xvid_pkg::mem_rsp_t  rsp_i,
    input  logic                clear_busy_i,
    output xvid_pkg::mem_req_t  req_o,
    output xvid_pkg::byte_t     bus_data_o
);

    xvid_pkg::word_t    reg_aux_addr;       // AUX address, auto increments
    xvid_pkg::word_t    reg_const;
    xvid_pkg::word_t    reg_rd_addr;
    xvid_pkg::word_t    reg_wr_addr;
    xvid_pkg::word_t    reg_rd_inc;
    xvid_pkg::word_t    reg_wr_inc;

    xvid_pkg::byte_t    reg_data_even;      // even byte of DATA/DATA_2
    xvid_pkg::byte_t    reg_other_even;     // even byte of any other register
    xvid_pkg::reg_num_t reg_other_reg;      // owner of reg_other_even

    xvid_pkg::word_t    vram_rd_data;
    xvid_pkg::word_t    aux_rd_data;

    xvid_pkg::byte_t    even_byte;
    xvid_pkg::word_t    odd_word;
    xvid_pkg::word_t    rd_word;
    logic               wr_even;
    logic               wr_odd;
    logic               rd_odd;
    logic               is_data;

    assign wr_even = acc_i.write & ~acc_i.bytesel;
    assign wr_odd  = acc_i.write & acc_i.bytesel;
    assign rd_odd  = acc_i.read & acc_i.bytesel;
    assign is_data = (acc_i.reg_num == xvid_pkg::DATA) || (acc_i.reg_num == xvid_pkg::DATA_2);

    // a stale even byte from another register reads as zero
    assign even_byte = (reg_other_reg == acc_i.reg_num) ? reg_other_even : 8'h00;
    assign odd_word  = {even_byte, acc_i.data};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_aux_addr   <= '0;
            reg_const      <= '0;
            reg_rd_addr    <= '0;
            reg_wr_addr    <= '0;
            reg_rd_inc     <= '0;
            reg_wr_inc     <= '0;
            reg_data_even  <= '0;
            reg_other_even <= '0;
            reg_other_reg  <= xvid_pkg::AUX_ADDR;
        end
        else begin
            if (wr_even) begin
                case (acc_i.reg_num)
                    xvid_pkg::AUX_ADDR: reg_aux_addr[15:8] <= acc_i.data;
                    xvid_pkg::RD_ADDR:  reg_rd_addr[15:8]  <= acc_i.data;
                    xvid_pkg::WR_ADDR:  reg_wr_addr[15:8]  <= acc_i.data;
                    xvid_pkg::DATA,
                    xvid_pkg::DATA_2:   reg_data_even      <= acc_i.data;
                    default: begin
                        reg_other_even <= acc_i.data;
                        reg_other_reg  <= acc_i.reg_num;
                    end
                endcase
            end

            if (wr_odd) begin
                case (acc_i.reg_num)
                    xvid_pkg::AUX_ADDR: reg_aux_addr[7:0] <= acc_i.data;
                    xvid_pkg::CONST:    reg_const         <= odd_word;
                    xvid_pkg::RD_ADDR:  reg_rd_addr[7:0]  <= acc_i.data;
                    xvid_pkg::WR_ADDR:  reg_wr_addr[7:0]  <= acc_i.data;
                    xvid_pkg::DATA,
                    xvid_pkg::DATA_2:   reg_wr_addr       <= reg_wr_addr + reg_wr_inc;
                    xvid_pkg::AUX_DATA: reg_aux_addr      <= reg_aux_addr + 16'd1;
                    xvid_pkg::RD_INC:   reg_rd_inc        <= odd_word;
                    xvid_pkg::WR_INC:   reg_wr_inc        <= odd_word;
                    default: ;                          // STATUS and unused are read only
                endcase
            end

            if (rd_odd && is_data) begin
                reg_rd_addr <= reg_rd_addr + reg_rd_inc;    // next word prefetched
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_i.vram_valid) begin
            vram_rd_data <= rsp_i.data;
        end
        if (rsp_i.aux_valid) begin
            aux_rd_data <= rsp_i.data;
        end
    end

    // request goes out in the strobe cycle, mem_port puts it on the pins
    always_comb begin
        req_o.vram = 1'b0;
        req_o.aux  = 1'b0;
        req_o.wr   = 1'b0;
        req_o.addr = reg_wr_addr;
        req_o.data = {reg_data_even, acc_i.data};

        if (wr_odd) begin
            case (acc_i.reg_num)
                xvid_pkg::AUX_ADDR: begin
                    req_o.aux  = 1'b1;                  // read at new address
                    req_o.addr = {reg_aux_addr[15:8], acc_i.data};
                end
                xvid_pkg::RD_ADDR: begin
                    req_o.vram = 1'b1;
                    req_o.addr = {reg_rd_addr[15:8], acc_i.data};
                end
                xvid_pkg::DATA,
                xvid_pkg::DATA_2: begin
                    req_o.vram = 1'b1;
                    req_o.wr   = 1'b1;
                end
                xvid_pkg::AUX_DATA: begin
                    req_o.aux  = 1'b1;
                    req_o.wr   = 1'b1;
                    req_o.addr = reg_aux_addr;
                    req_o.data = odd_word;
                end
                default: ;
            endcase
        end

        if (rd_odd && is_data) begin
            req_o.vram = 1'b1;
            req_o.addr = reg_rd_addr;
        end
    end

    always_comb begin
        case (acc_i.reg_num)
            xvid_pkg::AUX_ADDR: rd_word = reg_aux_addr;
            xvid_pkg::CONST:    rd_word = reg_const;
            xvid_pkg::RD_ADDR:  rd_word = reg_rd_addr;
            xvid_pkg::WR_ADDR:  rd_word = reg_wr_addr;
            xvid_pkg::DATA,
            xvid_pkg::DATA_2:   rd_word = vram_rd_data;
            xvid_pkg::AUX_DATA: rd_word = aux_rd_data;
            xvid_pkg::STATUS:   rd_word = {clear_busy_i, 7'h00, clear_busy_i, 7'h00};
            default:            rd_word = '0;   // increments are write only
        endcase
        bus_data_o = acc_i.bytesel ? rd_word[7:0] : rd_word[15:8];     // high byte on even lane
    end

endmodule

//--- xvid_top.sv
/*
 * video controller host register block
 * bus in, VRAM/AUX port and video enable out
 */
`include "xvid_macros.svh"

module xvid_top #(
    parameter int unsigned CLEAR_WORDS = `XV_CLEAR_WORDS
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bus_cs_n_i,
    input  logic                bus_rd_nwr_i,
    input  logic                bus_bytesel_i,
    input  xvid_pkg::reg_num_t  bus_reg_num_i,
    input  xvid_pkg::byte_t     bus_data_i,
    output xvid_pkg::byte_t     bus_data_o,
    input  logic                vgen_sel_i,
    output logic                vgen_ena_o,
    output logic                blit_vram_sel_o,
    output logic                blit_aux_sel_o,
    output logic                blit_wr_o,
    output xvid_pkg::word_t     blit_addr_o,
    input  xvid_pkg::word_t     blit_data_i,
    output xvid_pkg::word_t     blit_data_o,
    input  xvid_pkg::word_t     aux_data_i
);

    xvid_pkg::bus_acc_t acc;
    xvid_pkg::mem_req_t regs_req;
    xvid_pkg::mem_req_t init_req;
    xvid_pkg::mem_rsp_t rsp;
    logic               clear_busy;

    bus_sync u_bus_sync (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_data_i     (bus_data_i),
        .acc_o          (acc)
    );

    xvid_regs u_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .acc_i          (acc),
        .rsp_i          (rsp),
        .clear_busy_i   (clear_busy),
        .req_o          (regs_req),
        .bus_data_o     (bus_data_o)
    );

    vram_init #(
        .CLEAR_WORDS    (CLEAR_WORDS)
    ) u_init (
        .clk            (clk),
        .reset_i        (reset_i),
        .vgen_sel_i     (vgen_sel_i),
        .clear_busy_o   (clear_busy),
        .req_o          (init_req),
        .vgen_ena_o     (vgen_ena_o)
    );

    mem_port u_mem (
        .clk             (clk),
        .reset_i         (reset_i),
        .vgen_sel_i      (vgen_sel_i),
        .clear_busy_i    (clear_busy),
        .init_req_i      (init_req),
        .regs_req_i      (regs_req),
        .blit_data_i     (blit_data_i),
        .aux_data_i      (aux_data_i),
        .blit_vram_sel_o (blit_vram_sel_o),
        .blit_aux_sel_o  (blit_aux_sel_o),
        .blit_wr_o       (blit_wr_o),
        .blit_addr_o     (blit_addr_o),
        .blit_data_o     (blit_data_o),
        .rsp_o           (rsp)
    );

endmodule
